// ==== mulCtrl.sv ====
`timescale 1ns/100ps

module mulCtrl (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    output logic busy,
    output logic done,
    output logic opLoad,
    output logic treeLoad,
    output logic resLoad
);

    typedef enum logic [1:0] {
        IDLE,
        TREE,
        SUM,
        DONE
    } state_e;

    state_e state;
    state_e stateNext;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (start) begin
                    stateNext = TREE; // A start while busy never reaches here
                end
            end
            TREE:    stateNext = SUM;
            SUM:     stateNext = DONE;
            DONE:    stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    assign opLoad   = start && (state == IDLE);
    assign treeLoad = (state == TREE);
    assign resLoad  = (state == SUM);
    assign done     = (state == DONE);
    assign busy     = (state != IDLE);

    aDoneSingle: assert property (
        @(posedge clk) disable iff (!rstN)
        done |=> !done
    ) else $error("done held longer than one cycle");

    aLoadExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0({opLoad, treeLoad, resLoad})
    ) else $error("two stage loads active together");

endmodule

// ==== mulOperand.sv ====
`timescale 1ns/100ps
`include "mul_defines.svh"

module mulOperand (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 opLoad,
    input  mulPkg::mulReq_t      req,
    output logic [`MUL_XLEN-1:0] magA,
    output logic [`MUL_XLEN-1:0] magB,
    output logic                 negate,
    output logic                 highWord
);

    logic signA;
    logic signB;
    logic negA;
    logic negB;
    logic [`MUL_XLEN-1:0] absA;
    logic [`MUL_XLEN-1:0] absB;

    always_comb begin
        signA = (req.op == mulPkg::MULH) || (req.op == mulPkg::MULHSU);
        signB = (req.op == mulPkg::MULH);
    end

    assign negA = signA && req.op1[`MUL_XLEN-1];
    assign negB = signB && req.op2[`MUL_XLEN-1];

    // The most negative value maps to 2^31, which still fits unsigned
    assign absA = negA ? -req.op1 : req.op1;
    assign absB = negB ? -req.op2 : req.op2;

    always_ff @(posedge clk) begin
        if (opLoad) begin
            magA <= absA;
            magB <= absB;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            negate   <= 1'b0;
            highWord <= 1'b0;
        end else if (opLoad) begin
            negate   <= negA ^ negB;
            highWord <= (req.op != mulPkg::MUL);
        end
    end

    aUnsignedNoNegate: assert property (
        @(posedge clk) disable iff (!rstN)
        (opLoad && req.op == mulPkg::MULHU) |=> !negate
    ) else $error("negate set for an unsigned request");

endmodule

// ==== mulPkg.sv ====
`include "mul_defines.svh"

package mulPkg;

    typedef enum logic [1:0] {
        MUL    = 2'd0, // Low word
        MULH   = 2'd1, // High word, signed x signed
        MULHSU = 2'd2, // High word, signed x unsigned
        MULHU  = 2'd3  // High word, unsigned x unsigned
    } mulOp_e;

    typedef struct packed {
        logic [`MUL_XLEN-1:0] op1;
        logic [`MUL_XLEN-1:0] op2;
        mulOp_e               op;
    } mulReq_t;

    // Carry is kept at its own weight and shifted by the final adder
    typedef struct packed {
        logic [`MUL_PWIDTH-1:0] sum;
        logic [`MUL_PWIDTH-1:0] carry;
    } csPair_t;

    typedef union packed {
        logic [`MUL_PWIDTH-1:0] full;
        struct packed {
            logic [`MUL_XLEN-1:0] hi;
            logic [`MUL_XLEN-1:0] lo;
        } half;
    } product_u;

endpackage

// ==== mulResult.sv ====
`timescale 1ns/100ps
`include "mul_defines.svh"

module mulResult (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 resLoad,
    input  mulPkg::csPair_t      cs,
    input  logic                 negate,
    input  logic                 highWord,
    output logic [`MUL_XLEN-1:0] result
);

    logic [`MUL_PWIDTH-1:0] magProd;
    mulPkg::product_u       prod;
    logic [`MUL_XLEN-1:0]   word;

    // Carry bit 63 would land at 2^64 and falls off
    assign magProd = cs.sum + {cs.carry[`MUL_PWIDTH-2:0], 1'b0};

    always_comb begin
        if (negate) begin
            prod.full = -magProd;
        end else begin
            prod.full = magProd;
        end
    end

    assign word = highWord ? prod.half.hi : prod.half.lo;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (resLoad) begin
            result <= word; // Held until the next request arrives
        end
    end

endmodule

// ==== mulUnit.sv ====
`timescale 1ns/100ps
`include "mul_defines.svh"

module mulUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  mulPkg::mulReq_t      req,
    output logic                 busy,
    output logic                 done,
    output logic [`MUL_XLEN-1:0] result
);

    logic opLoad;
    logic treeLoad;
    logic resLoad;

    logic [`MUL_XLEN-1:0] magA;
    logic [`MUL_XLEN-1:0] magB;
    logic                 negate;
    logic                 highWord;
    logic                 negateTree;
    logic                 highWordTree;
    mulPkg::csPair_t      csPair;

    mulCtrl u_ctrl (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .opLoad   (opLoad),
        .treeLoad (treeLoad),
        .resLoad  (resLoad)
    );

    mulOperand u_operand (
        .clk      (clk),
        .rstN     (rstN),
        .opLoad   (opLoad),
        .req      (req),
        .magA     (magA),
        .magB     (magB),
        .negate   (negate),
        .highWord (highWord)
    );

    wallaceTree u_tree (
        .clk         (clk),
        .rstN        (rstN),
        .treeLoad    (treeLoad),
        .magA        (magA),
        .magB        (magB),
        .negateIn    (negate),
        .highWordIn  (highWord),
        .cs          (csPair),
        .negateOut   (negateTree),
        .highWordOut (highWordTree)
    );

    mulResult u_result (
        .clk      (clk),
        .rstN     (rstN),
        .resLoad  (resLoad),
        .cs       (csPair),
        .negate   (negateTree),
        .highWord (highWordTree),
        .result   (result)
    );

endmodule

// ==== mul_defines.svh ====
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Operand and product widths
`define MUL_XLEN    32
`define MUL_PWIDTH  64

// Rows entering each Wallace level, level 0 being the partial products
`define MUL_NL0     32
`define MUL_NL1     10
`define MUL_NL2     7
`define MUL_NL3     5
`define MUL_NL4     3
`define MUL_NL5     2
`define MUL_NL6     1
`define MUL_NL7     1
`define MUL_NL8     1

`endif

// ==== run.sh ====
#!/bin/bash
# Build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_mulUnit -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation returned an error"

grep -q "TEST OK" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== tb.f ====
+incdir+.
mulPkg.sv
mulCtrl.sv
mulOperand.sv
wallaceTree.sv
mulResult.sv
mulUnit.sv
tb_mulUnit.sv

// ==== tb_mulUnit.sv ====
`timescale 1ns/100ps
`include "mul_defines.svh"

module tb_mulUnit;

    localparam int clkPeriod = 40;
    localparam int nTests    = 456;
    localparam int timeoutNs = nTests * 5 * clkPeriod + 4000; // Margin covers reset and idle checks

    logic                 clk;
    logic                 rstN;
    logic                 start;
    mulPkg::mulReq_t      req;
    logic                 busy;
    logic                 done;
    logic [`MUL_XLEN-1:0] result;

    logic [31:0]    expQ [$];
    mulPkg::mulOp_e opQ [$];
    int             issued;
    int             doneCount;
    integer         seed;

    mulUnit u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Expected word from sign or zero extended operands
    function automatic logic [31:0] refMul(input mulPkg::mulOp_e op, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [63:0] extA;
        logic [63:0] extB;
        logic [63:0] prod;
        extA = {32'd0, a};
        extB = {32'd0, b};
        if (op == mulPkg::MULH || op == mulPkg::MULHSU) begin
            extA = {{32{a[31]}}, a};
        end
        if (op == mulPkg::MULH) begin
            extB = {{32{b[31]}}, b};
        end
        prod = extA * extB; // Low 64 bits hold the exact product
        return (op == mulPkg::MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic checkEqual(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Waits for done, checks busy on the way and returns the cycles since start
    task automatic waitDone(input int firstCycle, output int cycles);
        cycles = firstCycle;
        while (!done) begin
            checkEqual(32'(busy), 32'd1, "busy while waiting for done");
            if (cycles >= 10) begin
                $display("done did not arrive within 10 cycles of start");
                $display("TEST FAILED");
                $fatal(1);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic issueReq(input mulPkg::mulOp_e op, input logic [31:0] a, input logic [31:0] b);
        req.op1 = a;
        req.op2 = b;
        req.op  = op;
        start   = 1'b1;
        expQ.push_back(refMul(op, a, b));
        opQ.push_back(op);
        issued++;
    endtask

    task automatic runOne(input mulPkg::mulOp_e op, input logic [31:0] a, input logic [31:0] b);
        int cycles;
        @(negedge clk);
        issueReq(op, a, b);
        @(negedge clk);
        start = 1'b0;
        waitDone(1, cycles);
        checkEqual(32'(cycles), 32'd3, "cycles from start to done");
    endtask

    // Compares every done pulse against the oldest outstanding request
    initial begin : compareProc
        logic [31:0]    exp;
        mulPkg::mulOp_e op;
        forever begin
            @(negedge clk);
            if (rstN && done) begin
                doneCount++;
                if (expQ.size() == 0) begin
                    $display("done pulsed with no request outstanding");
                    $display("TEST FAILED");
                    $fatal(1);
                end else begin
                    exp = expQ.pop_front();
                    op  = opQ.pop_front();
                    checkEqual(result, exp, $sformatf("%s result", op.name()));
                end
            end
        end
    end

    initial begin : watchdog
        #(timeoutNs);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expHold;
        int          cycles;

        seed      = 32'h9bf7;
        issued    = 0;
        doneCount = 0;
        start     = 1'b0;
        req       = '0;
        rstN      = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkEqual(32'(busy), 32'd0, "busy after reset");
        checkEqual(32'(done), 32'd0, "done after reset");
        checkEqual(result, 32'd0, "result after reset");

        for (int i = 0; i < 200; i++) begin
            runOne(mulPkg::MUL, $random(seed), $random(seed));
        end

        for (int i = 0; i < 100; i++) begin
            runOne(mulPkg::MULHU, $random(seed), $random(seed));
        end
        runOne(mulPkg::MULHU, 32'hffff_ffff, 32'hffff_ffff);

        for (int i = 0; i < 100; i++) begin
            runOne(mulPkg::MULH, $random(seed), $random(seed));
        end
        runOne(mulPkg::MULH, 32'h8000_0000, 32'h8000_0000);
        runOne(mulPkg::MULH, 32'h8000_0000, 32'hffff_ffff);
        b = $random(seed);
        runOne(mulPkg::MULH, 32'd0, b | 32'h8000_0000);

        for (int i = 0; i < 50; i++) begin
            a = $random(seed);
            b = $random(seed);
            runOne(mulPkg::MULHSU, a | 32'h8000_0000, b | 32'h8000_0000); // Negative times large
        end

        // Result must hold while the unit sits idle
        a = $random(seed);
        b = $random(seed);
        runOne(mulPkg::MULH, a, b);
        expHold = refMul(mulPkg::MULH, a, b);
        repeat (6) begin
            @(negedge clk);
            checkEqual(result, expHold, "result held after done");
            checkEqual(32'(done), 32'd0, "done while idle");
            checkEqual(32'(busy), 32'd0, "busy while idle");
        end

        // A second start during busy must be dropped
        a = $random(seed);
        b = $random(seed);
        @(negedge clk);
        issueReq(mulPkg::MUL, a, b);
        expHold = refMul(mulPkg::MUL, a, b);
        @(negedge clk);
        checkEqual(32'(busy), 32'd1, "busy after accepted start");
        req.op1 = ~a;
        req.op2 = b + 32'd7;
        req.op  = mulPkg::MULHU;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waitDone(2, cycles);
        checkEqual(32'(cycles), 32'd3, "cycles from start to done with ignored start");
        checkEqual(result, expHold, "result after ignored start");
        repeat (6) begin
            @(negedge clk);
            checkEqual(32'(done), 32'd0, "extra done after ignored start");
        end

        checkEqual(32'(doneCount), 32'(issued), "done pulse count");
        checkEqual(32'(expQ.size()), 32'd0, "requests left without done");
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== wallaceTree.sv ====
`timescale 1ns/100ps
`include "mul_defines.svh"

module wallaceTree (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 treeLoad,
    input  logic [`MUL_XLEN-1:0] magA,
    input  logic [`MUL_XLEN-1:0] magB,
    input  logic                 negateIn,
    input  logic                 highWordIn,
    output mulPkg::csPair_t      cs,
    output logic                 negateOut,
    output logic                 highWordOut
);

    localparam int nLevels = 8;
    localparam int nRows [0:8] = '{
        `MUL_NL0, `MUL_NL1, `MUL_NL2, `MUL_NL3, `MUL_NL4,
        `MUL_NL5, `MUL_NL6, `MUL_NL7, `MUL_NL8
    };

    // Source of an input slot, coded as level * 64 + index
    function automatic int srcOf(input int level, input int slot);
        if (level == 1) begin
            return slot;
        end
        if (level == 7 && slot == 2) begin
            return 5 * 64 + 2 * nRows[5] - 1; // Carry left over from level 5
        end
        if (level == 8 && slot == 2) begin
            return 3 * 64 + 2 * nRows[3] - 1; // Carry left over from level 3
        end
        if ((level == 2 || level == 3) && slot >= 2 * nRows[level-1]) begin
            return `MUL_NL0 - 4 + level; // The last two partial products join late
        end
        return (level - 1) * 64 + slot;
    endfunction

    // Carries arrive unshifted, so each slot holding one is realigned here
    function automatic bit shiftOf(input int level, input int row, input int slot);
        if (level == 1) begin
            return 1'b0;
        end
        if (level >= 7) begin
            return slot != 0;
        end
        return (row % 2 == 0) ? (slot == 1) : (slot != 1);
    endfunction

    logic [`MUL_PWIDTH-1:0] node [0:nLevels][0:`MUL_NL0-1];

    always_comb begin : pReduce
        logic [`MUL_PWIDTH-1:0] opnd [3];
        int src;

        node = '{default: '0};
        for (int i = 0; i < `MUL_NL0; i++) begin
            if (magB[i]) begin
                node[0][i] = {{`MUL_XLEN{1'b0}}, magA} << i;
            end
        end

        for (int k = 1; k <= nLevels; k++) begin
            for (int r = 0; r < nRows[k]; r++) begin
                for (int s = 0; s < 3; s++) begin
                    src     = srcOf(k, 3 * r + s);
                    opnd[s] = node[src / 64][src % 64];
                    if (shiftOf(k, r, s)) begin
                        opnd[s] = {opnd[s][`MUL_PWIDTH-2:0], 1'b0};
                    end
                end
                node[k][2*r]   = opnd[0] ^ opnd[1] ^ opnd[2];
                node[k][2*r+1] = (opnd[0] & opnd[1]) | (opnd[0] & opnd[2]) |
                                 (opnd[1] & opnd[2]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (treeLoad) begin
            cs.sum   <= node[nLevels][0];
            cs.carry <= node[nLevels][1]; // Still at half weight
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            negateOut   <= 1'b0;
            highWordOut <= 1'b0;
        end else if (treeLoad) begin
            negateOut   <= negateIn;
            highWordOut <= highWordIn;
        end
    end

endmodule
